//--- design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } resp_t;

  // CLINT mtime window
  localparam addr_t clint_mtime_lo = 32'ha000_0048;
  localparam addr_t clint_mtime_hi = 32'ha000_004c;

  // ########################################
  // Channel payloads

  typedef struct packed {
    addr_t addr;
    logic  valid;
  } ar_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  valid;
  } r_rsp_t;

  typedef struct packed {
    addr_t      addr;
    data_t      data;
    logic [3:0] strb;
    logic       awvalid;
    logic       wvalid;
  } aw_w_req_t;

  typedef struct packed {
    resp_t resp;
    logic  valid;
  } b_rsp_t;

  // ########################################
  // Arbiter state

  typedef enum logic [1:0] {grant_fetch, grant_lsu, grant_none} grant_t;
  typedef enum logic [1:0] {target_clint, target_ext, target_none} target_t;
  typedef enum logic {arb_idle, arb_busy} arb_state_t;

endpackage

`default_nettype wire

//--- design/bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter
  import soc_bus_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // Fetch requester
  input  wire ar_req_t     fetch_ar,
  output logic             fetch_arready,
  output r_rsp_t           fetch_r,
  input  wire              fetch_rready,
  // LSU requester
  input  wire ar_req_t     lsu_ar,
  output logic             lsu_arready,
  input  wire aw_w_req_t   lsu_aw_w,
  output logic             lsu_awready,
  output logic             lsu_wready,
  output r_rsp_t           lsu_r,
  input  wire              lsu_rready,
  output b_rsp_t           lsu_b,
  input  wire              lsu_bready,
  // Timer target
  output ar_req_t          clint_ar,
  input  wire              clint_arready,
  output aw_w_req_t        clint_aw_w,
  input  wire              clint_awready,
  input  wire r_rsp_t      clint_r,
  output logic             clint_rready,
  input  wire b_rsp_t      clint_b,
  output logic             clint_bready,
  // External target
  output ar_req_t          ext_ar,
  input  wire              ext_arready,
  output aw_w_req_t        ext_aw_w,
  input  wire              ext_awready,
  input  wire r_rsp_t      ext_r,
  output logic             ext_rready,
  input  wire b_rsp_t      ext_b,
  output logic             ext_bready
);

  arb_state_t state;
  grant_t     grant;
  target_t    target;
  logic       is_write;  // Latched LSU write

  ar_req_t    req_ar;
  logic       req_rready;
  r_rsp_t     sel_r;
  b_rsp_t     sel_b;
  logic       sel_arready;
  logic       sel_awready;
  logic       done;

  function automatic target_t decode(input addr_t addr);
    target_t t;
    if (addr == clint_mtime_lo || addr == clint_mtime_hi) begin
      t = target_clint;
    end else begin
      t = target_ext;
    end
    return t;
  endfunction

  // ########################################
  // Grant FSM

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= arb_idle;
      grant    <= grant_none;
      target   <= target_none;
      is_write <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (fetch_ar.valid) begin  // Fetch first
            state    <= arb_busy;
            grant    <= grant_fetch;
            target   <= decode(fetch_ar.addr);
            is_write <= 1'b0;
          end else if (lsu_ar.valid) begin
            state    <= arb_busy;
            grant    <= grant_lsu;
            target   <= decode(lsu_ar.addr);
            is_write <= 1'b0;
          end else if (lsu_aw_w.awvalid && lsu_aw_w.wvalid) begin
            state    <= arb_busy;
            grant    <= grant_lsu;
            target   <= decode(lsu_aw_w.addr);
            is_write <= 1'b1;
          end
        end
        arb_busy: begin
          if (done) begin
            state    <= arb_idle;
            grant    <= grant_none;
            target   <= target_none;
            is_write <= 1'b0;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // ########################################
  // Steering and merge

  assign req_ar     = (grant == grant_fetch) ? fetch_ar : lsu_ar;
  assign req_rready = (grant == grant_fetch) ? fetch_rready : lsu_rready;

  always_comb begin
    sel_r       = '0;
    sel_b       = '0;
    sel_arready = 1'b0;
    sel_awready = 1'b0;
    case (target)
      target_clint: begin
        sel_r       = clint_r;
        sel_b       = clint_b;
        sel_arready = clint_arready;
        sel_awready = clint_awready;
      end
      target_ext: begin
        sel_r       = ext_r;
        sel_b       = ext_b;
        sel_arready = ext_arready;
        sel_awready = ext_awready;
      end
      default: ;
    endcase
  end

  // Ending R or B transfer
  assign done = is_write ? (sel_b.valid && lsu_bready) : (sel_r.valid && req_rready);

  always_comb begin
    clint_ar     = '0;
    clint_aw_w   = '0;
    clint_rready = 1'b0;
    clint_bready = 1'b0;
    ext_ar       = '0;
    ext_aw_w     = '0;
    ext_rready   = 1'b0;
    ext_bready   = 1'b0;
    if (state == arb_busy) begin
      if (target == target_clint) begin
        if (is_write) begin
          clint_aw_w   = lsu_aw_w;
          clint_bready = lsu_bready;
        end else begin
          clint_ar     = req_ar;
          clint_rready = req_rready;
        end
      end else if (target == target_ext) begin
        if (is_write) begin
          ext_aw_w   = lsu_aw_w;
          ext_bready = lsu_bready;
        end else begin
          ext_ar     = req_ar;
          ext_rready = req_rready;
        end
      end
    end
  end

  always_comb begin
    fetch_arready = 1'b0;
    fetch_r       = '0;
    lsu_arready   = 1'b0;
    lsu_awready   = 1'b0;
    lsu_wready    = 1'b0;
    lsu_r         = '0;
    lsu_b         = '0;
    if (state == arb_busy) begin
      if (grant == grant_fetch) begin
        fetch_arready = sel_arready;
        fetch_r       = sel_r;
      end else if (grant == grant_lsu && is_write) begin
        lsu_awready = sel_awready;
        lsu_wready  = sel_awready;  // AW and W go together
        lsu_b       = sel_b;
      end else if (grant == grant_lsu) begin
        lsu_arready = sel_arready;
        lsu_r       = sel_r;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/clint_timer.sv
`default_nettype none
`timescale 1ns/1ps

module clint_timer
  import soc_bus_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  wire ar_req_t   ar,
  output logic           arready,
  input  wire aw_w_req_t aw_w,
  output logic           awready,
  output r_rsp_t         r,
  input  wire            rready,
  output b_rsp_t         b,
  input  wire            bready
);

  logic [63:0] mtime;
  logic [31:0] mtime_hi_snap;  // Upper half taken at lo read

  logic        r_valid;
  data_t       r_data;
  resp_t       r_resp;
  logic        b_valid;

  logic        pending;
  logic        rd_accept;
  logic        wr_accept;

  assign pending   = r_valid || b_valid;
  assign arready   = !pending;
  assign awready   = !pending && !ar.valid;
  assign rd_accept = ar.valid && arready;
  assign wr_accept = aw_w.awvalid && aw_w.wvalid && awready;

  // ########################################
  // Free-running counter

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= 64'd0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // ########################################
  // Response slots

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (rd_accept) begin
        r_valid <= 1'b1;
      end else if (r_valid && rready) begin
        r_valid <= 1'b0;
      end
      if (wr_accept) begin
        b_valid <= 1'b1;  // mtime is read-only
      end else if (b_valid && bready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) begin
      if (ar.addr == clint_mtime_lo) begin
        r_data        <= mtime[31:0];
        r_resp        <= resp_okay;
        mtime_hi_snap <= mtime[63:32];
      end else if (ar.addr == clint_mtime_hi) begin
        r_data <= mtime_hi_snap;
        r_resp <= resp_okay;
      end else begin
        r_data <= '0;
        r_resp <= resp_slverr;
      end
    end
  end

  assign r = '{data: r_data, resp: r_resp, valid: r_valid};
  assign b = '{resp: resp_slverr, valid: b_valid};

endmodule

`default_nettype wire

//--- design/soc_bus_top.sv
`default_nettype none
`timescale 1ns/1ps

module soc_bus_top
  import soc_bus_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // Fetch port
  input  wire ar_req_t     fetch_ar,
  output logic             fetch_arready,
  output r_rsp_t           fetch_r,
  input  wire              fetch_rready,
  // LSU port
  input  wire ar_req_t     lsu_ar,
  output logic             lsu_arready,
  input  wire aw_w_req_t   lsu_aw_w,
  output logic             lsu_awready,
  output logic             lsu_wready,
  output r_rsp_t           lsu_r,
  input  wire              lsu_rready,
  output b_rsp_t           lsu_b,
  input  wire              lsu_bready,
  // External AXI-Lite port
  output ar_req_t          ext_ar,
  input  wire              ext_arready,
  output aw_w_req_t        ext_aw_w,
  input  wire              ext_awready,
  input  wire r_rsp_t      ext_r,
  output logic             ext_rready,
  input  wire b_rsp_t      ext_b,
  output logic             ext_bready
);

  // Arbiter to timer
  ar_req_t   clint_ar;
  aw_w_req_t clint_aw_w;
  logic      clint_arready;
  logic      clint_awready;
  r_rsp_t    clint_r;
  b_rsp_t    clint_b;
  logic      clint_rready;
  logic      clint_bready;

  bus_arbiter arb0 (
    .clock         (clock),
    .reset         (reset),
    .fetch_ar      (fetch_ar),
    .fetch_arready (fetch_arready),
    .fetch_r       (fetch_r),
    .fetch_rready  (fetch_rready),
    .lsu_ar        (lsu_ar),
    .lsu_arready   (lsu_arready),
    .lsu_aw_w      (lsu_aw_w),
    .lsu_awready   (lsu_awready),
    .lsu_wready    (lsu_wready),
    .lsu_r         (lsu_r),
    .lsu_rready    (lsu_rready),
    .lsu_b         (lsu_b),
    .lsu_bready    (lsu_bready),
    .clint_ar      (clint_ar),
    .clint_arready (clint_arready),
    .clint_aw_w    (clint_aw_w),
    .clint_awready (clint_awready),
    .clint_r       (clint_r),
    .clint_rready  (clint_rready),
    .clint_b       (clint_b),
    .clint_bready  (clint_bready),
    .ext_ar        (ext_ar),
    .ext_arready   (ext_arready),
    .ext_aw_w      (ext_aw_w),
    .ext_awready   (ext_awready),
    .ext_r         (ext_r),
    .ext_rready    (ext_rready),
    .ext_b         (ext_b),
    .ext_bready    (ext_bready)
  );

  clint_timer clint0 (
    .clock   (clock),
    .reset   (reset),
    .ar      (clint_ar),
    .arready (clint_arready),
    .aw_w    (clint_aw_w),
    .awready (clint_awready),
    .r       (clint_r),
    .rready  (clint_rready),
    .b       (clint_b),
    .bready  (clint_bready)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- test/ext_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module ext_mem_model
  import soc_bus_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  wire ar_req_t   ar,
  output logic           arready,
  input  wire aw_w_req_t aw_w,
  output logic           awready,
  output r_rsp_t         r,
  input  wire            rready,
  output b_rsp_t         b,
  input  wire            bready
);

  localparam addr_t mem_base  = 32'h8000_0000;
  localparam data_t seed_mask = 32'ha5a5_0000;

  data_t      mem [0:63];
  logic       pend;
  logic       pend_read;
  logic [1:0] delay;
  data_t      rdata;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = (mem_base + 32'(i * 4)) ^ seed_mask;
    end
  end

  assign arready = !pend;
  assign awready = !pend && !ar.valid;
  assign r = '{data: rdata, resp: resp_okay, valid: pend && pend_read && delay == 2'd0};
  assign b = '{resp: resp_okay, valid: pend && !pend_read && delay == 2'd0};

  always @(posedge clock) begin
    if (reset) begin
      pend      <= 1'b0;
      pend_read <= 1'b0;
      delay     <= 2'd0;
    end else if (!pend && ar.valid) begin
      pend      <= 1'b1;
      pend_read <= 1'b1;
      delay     <= 2'($urandom_range(3));
      rdata     <= mem[ar.addr[7:2]];
    end else if (!pend && aw_w.awvalid && aw_w.wvalid) begin
      pend      <= 1'b1;
      pend_read <= 1'b0;
      delay     <= 2'($urandom_range(3));
      for (int k = 0; k < 4; k++) begin
        if (aw_w.strb[k]) mem[aw_w.addr[7:2]][k*8 +: 8] <= aw_w.data[k*8 +: 8];
      end
    end else if (pend && delay != 2'd0) begin
      delay <= delay - 2'd1;
    end else if ((r.valid && rready) || (b.valid && bready)) begin
      pend <= 1'b0;  // Response taken
    end
  end

endmodule

`default_nettype wire

//--- test/bus_checker.sv
`default_nettype none
`timescale 1ns/1ps

module bus_checker
  import soc_bus_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  wire r_rsp_t fetch_r,
  input  wire         fetch_rready,
  input  wire r_rsp_t lsu_r,
  input  wire         lsu_rready,
  input  wire b_rsp_t lsu_b,
  input  wire         lsu_bready
);

  // Data modes: 0 exact, 1 record mtime, 2 above recorded mtime, 3 response only
  string  slot_name [2];
  logic   slot_on [2];
  logic   slot_write [2];
  data_t  slot_data [2];
  resp_t  slot_resp [2];
  int     slot_mode [2];
  data_t  last_lo;
  r_rsp_t fetch_hold;
  r_rsp_t lsu_hold;
  logic   fetch_stall;
  logic   lsu_stall;
  int     test_count = 0;
  int     pass_count = 0;
  int     error_count = 0;

  initial begin
    slot_on[0] = 1'b0;
    slot_on[1] = 1'b0;
  end

  task automatic arm_slot(input string name, input int port, input logic is_write,
                          input data_t data, input resp_t resp, input int mode);
    slot_name[port]  = name;
    slot_write[port] = is_write;
    slot_data[port]  = data;
    slot_resp[port]  = resp;
    slot_mode[port]  = mode;
    slot_on[port]    = 1'b1;
  endtask

  task automatic close_slot(input int port, input data_t data, input resp_t resp);
    logic ok;
    ok = 1'b1;
    if (port == 1 && slot_on[0]) begin
      $display("test %s: LSU response finished while fetch was still waiting", slot_name[1]);
      ok = 1'b0;
    end
    if (resp != slot_resp[port]) begin
      $display("mismatch %s resp expected %0d actual %0d", slot_name[port], slot_resp[port], resp);
      ok = 1'b0;
    end
    if (slot_mode[port] == 0 && data != slot_data[port]) begin
      $display("mismatch %s data expected %h actual %h", slot_name[port], slot_data[port], data);
      ok = 1'b0;
    end
    if (slot_mode[port] == 2 && !(data > last_lo)) begin
      $display("mismatch %s data expected above %h actual %h", slot_name[port], last_lo, data);
      ok = 1'b0;
    end
    if (slot_mode[port] == 1 || slot_mode[port] == 2) last_lo = data;
    test_count++;
    if (ok) pass_count++;
    else error_count++;
    $display("test %s: %s", slot_name[port], ok ? "ok" : "failed");
    slot_on[port] = 1'b0;
  endtask

  // ########################################
  // Transfer monitor

  always @(posedge clock) begin
    if (!reset) begin
      if (fetch_r.valid && !(slot_on[0] && !slot_write[0])) begin
        $display("error: read response on fetch port with no fetch read pending");
        error_count++;
      end
      if (lsu_r.valid && !(slot_on[1] && !slot_write[1])) begin
        $display("error: read response on LSU port with no LSU read pending");
        error_count++;
      end
      if (lsu_r.valid && slot_on[0]) begin
        $display("error: read response on LSU port while fetch read still granted");
        error_count++;
      end
      if (lsu_b.valid && !(slot_on[1] && slot_write[1])) begin
        $display("error: write response on LSU port with no LSU write pending");
        error_count++;
      end
      if (fetch_stall && fetch_r != fetch_hold) begin
        $display("error: fetch read response changed while stalled");
        error_count++;
      end
      if (lsu_stall && lsu_r != lsu_hold) begin
        $display("error: LSU read response changed while stalled");
        error_count++;
      end
      fetch_stall = fetch_r.valid && !fetch_rready;
      fetch_hold  = fetch_r;
      lsu_stall   = lsu_r.valid && !lsu_rready;
      lsu_hold    = lsu_r;
      if (fetch_r.valid && fetch_rready && slot_on[0]) close_slot(0, fetch_r.data, fetch_r.resp);
      if (lsu_r.valid && lsu_rready && slot_on[1]) close_slot(1, lsu_r.data, lsu_r.resp);
      if (lsu_b.valid && lsu_bready && slot_on[1]) close_slot(1, '0, lsu_b.resp);
    end
  end

  task automatic report_counts();
    $display("tests %0d, passed %0d, errors %0d", test_count, pass_count, error_count);
  endtask

endmodule

`default_nettype wire

//--- test/soc_bus_properties.sv
`default_nettype none
`timescale 1ns/1ps

module soc_bus_properties
  import soc_bus_pkg::*;
(
  input wire         clock,
  input wire         reset,
  input wire r_rsp_t fetch_r,
  input wire         fetch_rready,
  input wire         fetch_arready,
  input wire r_rsp_t lsu_r,
  input wire         lsu_rready,
  input wire         lsu_arready,
  input wire         lsu_awready,
  input wire b_rsp_t lsu_b,
  input wire         lsu_bready
);

  int fail_count = 0;  // Failed assertions so far

  fetch_r_stable: assert property (@(posedge clock) disable iff (reset)
    fetch_r.valid && !fetch_rready |=> fetch_r.valid && $stable(fetch_r))
    else begin
      fail_count++;
      $error("fetch R changed before transfer");
    end

  lsu_r_stable: assert property (@(posedge clock) disable iff (reset)
    lsu_r.valid && !lsu_rready |=> lsu_r.valid && $stable(lsu_r))
    else begin
      fail_count++;
      $error("LSU R changed before transfer");
    end

  lsu_b_stable: assert property (@(posedge clock) disable iff (reset)
    lsu_b.valid && !lsu_bready |=> lsu_b.valid && $stable(lsu_b))
    else begin
      fail_count++;
      $error("LSU B changed before transfer");
    end

  one_requester: assert property (@(posedge clock) disable iff (reset)
    !(fetch_r.valid && (lsu_r.valid || lsu_b.valid)))
    else begin
      fail_count++;
      $error("both requesters see a response");
    end

  idle_after_reset: assert property (@(posedge clock)
    reset |=> !fetch_r.valid && !lsu_r.valid && !lsu_b.valid
              && !fetch_arready && !lsu_arready && !lsu_awready)
    else begin
      fail_count++;
      $error("outputs active after reset");
    end

endmodule

bind bus_arbiter soc_bus_properties props0 (
  .clock         (clock),
  .reset         (reset),
  .fetch_r       (fetch_r),
  .fetch_rready  (fetch_rready),
  .fetch_arready (fetch_arready),
  .lsu_r         (lsu_r),
  .lsu_rready    (lsu_rready),
  .lsu_arready   (lsu_arready),
  .lsu_awready   (lsu_awready),
  .lsu_b         (lsu_b),
  .lsu_bready    (lsu_bready)
);

`default_nettype wire

//--- test/soc_bus_tb.sv
`default_nettype none
`timescale 1ns/1ps

module soc_bus_tb
  import soc_bus_pkg::*;
;

  localparam int port_fetch = 0;
  localparam int port_lsu   = 1;
  localparam int port_both  = 2;
  localparam int num_rows   = 12;
  localparam int cycle_limit = num_rows * 40;

  typedef struct {
    string name;
    int    port;
    logic  is_write;
    addr_t addr;
    data_t wdata;
    logic [3:0] strb;
    data_t exp_data;
    resp_t exp_resp;
    int    mode;      // 0 exact, 1 record mtime, 2 above mtime, 3 response only
    addr_t addr2;     // LSU side of a dual read
    data_t exp_data2;
  } row_t;

  row_t rows [num_rows];

  logic      clock;
  logic      reset;
  ar_req_t   fetch_ar;
  logic      fetch_rready;
  ar_req_t   lsu_ar;
  aw_w_req_t lsu_aw_w;
  logic      lsu_rready;
  logic      lsu_bready;
  logic      fetch_arready;
  r_rsp_t    fetch_r;
  logic      lsu_arready;
  logic      lsu_awready;
  logic      lsu_wready;
  r_rsp_t    lsu_r;
  b_rsp_t    lsu_b;
  ar_req_t   ext_ar;
  logic      ext_arready;
  aw_w_req_t ext_aw_w;
  logic      ext_awready;
  r_rsp_t    ext_r;
  logic      ext_rready;
  b_rsp_t    ext_b;
  logic      ext_bready;
  int        cycles = 0;
  int        armed = 0;

  tb_clock_gen clk0 (.clock(clock), .reset(reset));

  soc_bus_top dut0 (.*);

  ext_mem_model mem0 (
    .clock (clock), .reset (reset),
    .ar (ext_ar), .arready (ext_arready), .aw_w (ext_aw_w), .awready (ext_awready),
    .r (ext_r), .rready (ext_rready), .b (ext_b), .bready (ext_bready)
  );

  bus_checker chk0 (
    .clock (clock), .reset (reset),
    .fetch_r (fetch_r), .fetch_rready (fetch_rready),
    .lsu_r (lsu_r), .lsu_rready (lsu_rready), .lsu_b (lsu_b), .lsu_bready (lsu_bready)
  );

  // External words start as address XOR a5a5_0000
  initial begin
    rows[0]  = '{"fetch_ext_read", 0, 0, 32'h8000_0010, 0, 0, 32'h25a5_0010, resp_okay, 0, 0, 0};
    rows[1]  = '{"lsu_write_full", 1, 1, 32'h8000_0030, 32'hdead_beef, 4'hf, 0, resp_okay, 3, 0, 0};
    rows[2]  = '{"lsu_read_full", 1, 0, 32'h8000_0030, 0, 0, 32'hdead_beef, resp_okay, 0, 0, 0};
    rows[3]  = '{"lsu_write_strb", 1, 1, 32'h8000_0020, 32'h1122_3344, 4'h5, 0, resp_okay, 3, 0, 0};
    rows[4]  = '{"lsu_read_strb", 1, 0, 32'h8000_0020, 0, 0, 32'h2522_0044, resp_okay, 0, 0, 0};
    rows[5]  = '{"mtime_lo_first", 1, 0, clint_mtime_lo, 0, 0, 0, resp_okay, 1, 0, 0};
    rows[6]  = '{"mtime_lo_second", 1, 0, clint_mtime_lo, 0, 0, 0, resp_okay, 2, 0, 0};
    rows[7]  = '{"mtime_hi", 1, 0, clint_mtime_hi, 0, 0, 0, resp_okay, 0, 0, 0};
    rows[8]  = '{"mtime_write", 1, 1, clint_mtime_lo, 32'h1, 4'hf, 0, resp_slverr, 3, 0, 0};
    rows[9]  = '{"mtime_lo_after_write", 1, 0, clint_mtime_lo, 0, 0, 0, resp_okay, 2, 0, 0};
    rows[10] = '{"dual_read", 2, 0, 32'h8000_0004, 0, 0, 32'h25a5_0004, resp_okay, 0,
                 32'h8000_0008, 32'h25a5_0008};
    rows[11] = '{"fetch_ext_last", 0, 0, 32'h8000_00fc, 0, 0, 32'h25a5_00fc, resp_okay, 0, 0, 0};
  end

  task automatic run_read(input int port, input addr_t addr);
    logic ar_on;
    logic ar_drop;
    logic finished;
    logic rr;
    ar_on    = 1'b1;
    ar_drop  = 1'b0;
    finished = 1'b0;
    if (port == port_fetch) fetch_ar = '{addr: addr, valid: 1'b1};
    else lsu_ar = '{addr: addr, valid: 1'b1};
    while (!finished) begin
      @(negedge clock);
      if (ar_drop) begin
        if (port == port_fetch) fetch_ar = '0;
        else lsu_ar = '0;
        ar_on   = 1'b0;
        ar_drop = 1'b0;
      end
      rr = ($urandom_range(2) != 0);  // Random back-pressure
      if (port == port_fetch) begin
        fetch_rready = rr;
        if (ar_on && fetch_arready) ar_drop = 1'b1;
        if (fetch_r.valid && rr) finished = 1'b1;
      end else begin
        lsu_rready = rr;
        if (ar_on && lsu_arready) ar_drop = 1'b1;
        if (lsu_r.valid && rr) finished = 1'b1;
      end
    end
    @(negedge clock);
    if (port == port_fetch) fetch_rready = 1'b0;
    else lsu_rready = 1'b0;
  endtask

  task automatic run_write(input addr_t addr, input data_t data, input logic [3:0] strb);
    logic aw_drop;
    logic finished;
    logic br;
    aw_drop  = 1'b0;
    finished = 1'b0;
    lsu_aw_w = '{addr: addr, data: data, strb: strb, awvalid: 1'b1, wvalid: 1'b1};
    while (!finished) begin
      @(negedge clock);
      if (aw_drop) begin
        lsu_aw_w = '0;
        aw_drop  = 1'b0;
      end
      br = ($urandom_range(2) != 0);
      lsu_bready = br;
      if (lsu_aw_w.awvalid && lsu_awready && lsu_wready) aw_drop = 1'b1;
      if (lsu_b.valid && br) finished = 1'b1;
    end
    @(negedge clock);
    lsu_bready = 1'b0;
  endtask

  // ########################################
  // Main sequence

  initial begin
    fetch_ar     = '0;
    fetch_rready = 1'b0;
    lsu_ar       = '0;
    lsu_aw_w     = '0;
    lsu_rready   = 1'b0;
    lsu_bready   = 1'b0;
    void'($urandom(41750));
    @(negedge clock);
    while (reset) @(negedge clock);
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clock);
      if (rows[i].port == port_both) begin
        chk0.arm_slot({rows[i].name, "_fetch"}, port_fetch, 1'b0, rows[i].exp_data,
                      rows[i].exp_resp, rows[i].mode);
        chk0.arm_slot({rows[i].name, "_lsu"}, port_lsu, 1'b0, rows[i].exp_data2,
                      rows[i].exp_resp, rows[i].mode);
        armed += 2;
        fork
          run_read(port_fetch, rows[i].addr);
          run_read(port_lsu, rows[i].addr2);
        join
      end else begin
        chk0.arm_slot(rows[i].name, rows[i].port, rows[i].is_write, rows[i].exp_data,
                      rows[i].exp_resp, rows[i].mode);
        armed++;
        if (rows[i].is_write) run_write(rows[i].addr, rows[i].wdata, rows[i].strb);
        else run_read(rows[i].port, rows[i].addr);
      end
    end
    repeat (2) @(negedge clock);
    if (chk0.test_count != armed) begin
      $display("only %0d of %0d tests finished", chk0.test_count, armed);
    end
    if (dut0.arb0.props0.fail_count != 0) begin
      $display("%0d bus assertion failures", dut0.arb0.props0.fail_count);
    end
    chk0.report_counts();
    if (chk0.error_count == 0 && chk0.test_count == armed &&
        dut0.arb0.props0.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit + 8) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
design/soc_bus_pkg.sv
design/bus_arbiter.sv
design/clint_timer.sv
design/soc_bus_top.sv
test/tb_clock_gen.sv
test/ext_mem_model.sv
test/bus_checker.sv
test/soc_bus_properties.sv
test/soc_bus_tb.sv

//--- Makefile
# Verilator build for the SoC bus crossbar testbench

VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) design/*.sv test/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
